// ==== hdl/usb_out_pkg.sv ====
`default_nettype none

package usb_out_pkg;

  //////////////////////////////////////////////////////////////////////
  // Endpoint and packet sizes
  //////////////////////////////////////////////////////////////////////

  // Implemented OUT endpoints
  localparam int unsigned NUM_OUT_EPS = 2;
  localparam int unsigned OUT_EP_W = 1;

  // Largest packet and put offset width
  localparam int unsigned MAX_PKT_BYTES = 32;
  localparam int unsigned PKT_W = 5;

  // 17 bit times at 4 cycles per bit on the 48 MHz clock
  localparam int unsigned ACK_TIMEOUT_CNT = 68;
  localparam int unsigned TIMEOUT_W = 7;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // PIDs seen or sent by this engine, low nibble only
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_e;

  // PID class from the two low PID bits
  typedef enum logic [1:0] {
    PID_TYPE_SPECIAL   = 2'b00,
    PID_TYPE_TOKEN     = 2'b01,
    PID_TYPE_HANDSHAKE = 2'b10,
    PID_TYPE_DATA      = 2'b11
  } usb_pid_type_e;

  // OUT transaction states
  typedef enum logic [2:0] {
    ST_IDLE            = 3'd0,
    ST_RCVD_OUT        = 3'd1,
    ST_RCVD_DATA_START = 3'd2,
    ST_RCVD_DATA_END   = 3'd3
  } out_state_e;

  //////////////////////////////////////////////////////////////////////
  // Port bundles
  //////////////////////////////////////////////////////////////////////

  // Received packet, strobes plus the latest header fields
  typedef struct packed {
    logic       pkt_start;
    logic       pkt_end;
    logic       pkt_valid;
    logic [3:0] pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } rx_pkt_s;

  // Per-endpoint configuration and status
  typedef struct packed {
    logic [NUM_OUT_EPS-1:0] enabled;
    logic [NUM_OUT_EPS-1:0] control;
    logic [NUM_OUT_EPS-1:0] full;
    logic [NUM_OUT_EPS-1:0] stall;
  } ep_cfg_s;

  // Byte put toward the endpoint
  typedef struct packed {
    logic             put;
    logic [PKT_W-1:0] offset;
    logic [7:0]       data;
  } ep_put_s;

  // Decoded packet events, one strobe each
  typedef struct packed {
    logic out_tok;
    logic setup_tok;
    logic data_pkt;
    logic bad_pkt;
    logic bad_toggle;
    logic setup_clr;
  } rx_event_s;

endpackage

`default_nettype wire

// ==== hdl/usb_out_token_decode.sv ====
`default_nettype none

module usb_out_token_decode import usb_out_pkg::*; (
  input  rx_pkt_s                rx_pkt_i,
  input  logic [6:0]             dev_addr_i,
  input  ep_cfg_s                ep_cfg_i,
  input  logic [NUM_OUT_EPS-1:0] data_toggle_i,
  output rx_event_s              rx_event_o,
  output logic [OUT_EP_W-1:0]    ep_idx_o
);

  usb_pid_type_e pid_type;
  logic          token_rcvd;
  logic          is_data_pid;
  logic          ep_in_hw;
  logic          ep_active;
  logic          ep_is_control;

  //////////////////////////////////////////////////////////////////////
  // Packet classification
  //////////////////////////////////////////////////////////////////////

  assign pid_type = usb_pid_type_e'(rx_pkt_i.pid[1:0]);

  // Valid token for this device
  assign token_rcvd = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid &&
                      (pid_type == PID_TYPE_TOKEN) && (rx_pkt_i.addr == dev_addr_i);

  assign is_data_pid = (rx_pkt_i.pid == PID_DATA0) || (rx_pkt_i.pid == PID_DATA1);

  //////////////////////////////////////////////////////////////////////
  // Endpoint selection
  //////////////////////////////////////////////////////////////////////

  // Endpoint numbers above the implemented range map to 0
  assign ep_in_hw = rx_pkt_i.endp < 4'(NUM_OUT_EPS);
  assign ep_idx_o = ep_in_hw ? rx_pkt_i.endp[OUT_EP_W-1:0] : '0;

  // Index only meaningful together with ep_in_hw
  assign ep_active     = ep_in_hw && ep_cfg_i.enabled[ep_idx_o];
  assign ep_is_control = ep_cfg_i.control[ep_idx_o];

  //////////////////////////////////////////////////////////////////////
  // Events
  //////////////////////////////////////////////////////////////////////

  assign rx_event_o.out_tok   = token_rcvd && ep_active && (rx_pkt_i.pid == PID_OUT);

  // SETUP only starts a transaction on a control endpoint
  assign rx_event_o.setup_tok = token_rcvd && ep_active && ep_is_control &&
                                (rx_pkt_i.pid == PID_SETUP);

  // Flag and toggle side reacts to SETUP on any active endpoint
  assign rx_event_o.setup_clr = token_rcvd && ep_active && (rx_pkt_i.pid == PID_SETUP);

  assign rx_event_o.data_pkt  = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid && is_data_pid;

  // Bad CRC or a non-data packet where data was expected
  assign rx_event_o.bad_pkt   = rx_pkt_i.pkt_end && (!rx_pkt_i.pkt_valid || !is_data_pid);

  // PID bit 3 is the DATA0/DATA1 toggle
  assign rx_event_o.bad_toggle = rx_event_o.data_pkt && ep_active &&
                                 (rx_pkt_i.pid[3] != data_toggle_i[ep_idx_o]);

endmodule

`default_nettype wire

// ==== hdl/usb_out_xact_fsm.sv ====
`default_nettype none

module usb_out_xact_fsm import usb_out_pkg::*; (
  input  logic                clk_48mhz_i,
  input  logic                rst_ni,
  input  logic                link_reset_i,
  input  logic                rx_pkt_start_i,
  input  rx_event_s           rx_event_i,
  input  logic [OUT_EP_W-1:0] ep_idx_i,
  input  ep_cfg_s             ep_cfg_i,
  input  logic                nak_i,
  output out_state_e          state_o,
  output logic                xact_start_o,
  output logic                new_pkt_end_o,
  output logic [OUT_EP_W-1:0] ep_current_o,
  output logic                ep_newpkt_o,
  output logic                ep_acked_o,
  output logic                ep_rollback_o,
  output logic                tx_pkt_start_o,
  output usb_pid_e            tx_pid_o
);

  out_state_e           state_q;
  out_state_e           state_d;
  logic [TIMEOUT_W-1:0] timeout_q;
  logic [TIMEOUT_W-1:0] timeout_d;
  logic                 setup_q;
  logic                 ep_full;
  logic                 ep_stall;

  // Status of the endpoint latched at token time
  assign ep_full  = ep_cfg_i.full[ep_current_o];
  assign ep_stall = ep_cfg_i.stall[ep_current_o];

  //////////////////////////////////////////////////////////////////////
  // Next state and response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    timeout_d      = TIMEOUT_W'(ACK_TIMEOUT_CNT);
    xact_start_o   = 1'b0;
    new_pkt_end_o  = 1'b0;
    ep_acked_o     = 1'b0;
    ep_rollback_o  = 1'b0;
    tx_pkt_start_o = 1'b0;
    tx_pid_o       = PID_ACK;

    unique case (state_q)
      ST_IDLE: begin
        // Decoder already filtered address, enable and control
        if (rx_event_i.out_tok || rx_event_i.setup_tok) begin
          state_d      = ST_RCVD_OUT;
          xact_start_o = 1'b1;
        end
      end

      ST_RCVD_OUT: begin
        // Bounded wait for the host data packet
        timeout_d = timeout_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = ST_RCVD_DATA_START;
        end else if (timeout_q == '0) begin
          state_d = ST_IDLE;
        end
      end

      ST_RCVD_DATA_START: begin
        if (rx_event_i.bad_toggle && !ep_stall) begin
          // Host likely missed our last ACK, so ACK again and drop the data
          state_d        = ST_IDLE;
          ep_rollback_o  = 1'b1;
          tx_pkt_start_o = 1'b1;
          tx_pid_o       = PID_ACK;
        end else if (rx_event_i.bad_pkt) begin
          // Corrupt or unexpected packet, stay silent
          state_d       = ST_IDLE;
          ep_rollback_o = 1'b1;
        end else if (rx_event_i.data_pkt) begin
          state_d = ST_RCVD_DATA_END;
        end
      end

      ST_RCVD_DATA_END: begin
        state_d        = ST_IDLE;
        tx_pkt_start_o = 1'b1;
        if (setup_q) begin
          // SETUP that cannot be stored is dropped without a handshake
          if (nak_i || ep_full) begin
            tx_pkt_start_o = 1'b0;
            ep_rollback_o  = 1'b1;
          end else begin
            new_pkt_end_o = 1'b1;
            ep_acked_o    = 1'b1;
          end
        end else if (ep_stall) begin
          tx_pid_o = PID_STALL;
        end else if (nak_i || ep_full) begin
          tx_pid_o      = PID_NAK;
          ep_rollback_o = 1'b1;
        end else begin
          new_pkt_end_o = 1'b1;
          ep_acked_o    = 1'b1;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      timeout_q <= TIMEOUT_W'(ACK_TIMEOUT_CNT);
    end else begin
      state_q   <= link_reset_i ? ST_IDLE : state_d;
      timeout_q <= timeout_d;
    end
  end

  // Transaction context, held until the next token
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ep_newpkt_o  <= 1'b0;
      ep_current_o <= '0;
      setup_q      <= 1'b0;
    end else if (xact_start_o && !link_reset_i) begin
      ep_newpkt_o  <= 1'b1;
      ep_current_o <= ep_idx_i;
      setup_q      <= rx_event_i.setup_tok;
    end else begin
      ep_newpkt_o <= 1'b0;
    end
  end

  assign state_o = state_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  state_legal_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    state_q inside {ST_IDLE, ST_RCVD_OUT, ST_RCVD_DATA_START, ST_RCVD_DATA_END});

  // Endpoint never sees commit and discard for one packet
  acked_rollback_excl_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(ep_acked_o && ep_rollback_o));

endmodule

`default_nettype wire

// ==== hdl/usb_out_data_path.sv ====
`default_nettype none

module usb_out_data_path import usb_out_pkg::*; (
  input  logic       clk_48mhz_i,
  input  logic       rst_ni,
  input  out_state_e state_i,
  input  logic       rx_data_put_i,
  input  logic [7:0] rx_data_i,
  input  logic       ep_full_i,
  output ep_put_s    ep_put_o,
  output logic       nak_o
);

  logic             put_q;
  logic [PKT_W-1:0] offset_q;
  logic [7:0]       data_q;
  logic             nak_q;
  logic             offset_inc;

  //////////////////////////////////////////////////////////////////////
  // Byte capture and put strobe
  //////////////////////////////////////////////////////////////////////

  // Payload only, follows every rx byte
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      data_q <= rx_data_i;
    end
  end

  // Put only while a data packet of a live transaction streams in
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_q <= 1'b0;
    end else begin
      put_q <= (state_i == ST_RCVD_DATA_START) && rx_data_put_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // NAK tracking
  //////////////////////////////////////////////////////////////////////

  // Any byte arriving at a full endpoint dooms the transaction
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_q <= 1'b0;
    end else if ((state_i == ST_IDLE) || (state_i == ST_RCVD_OUT)) begin
      nak_q <= 1'b0;
    end else if (put_q && ep_full_i) begin
      nak_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Put offset
  //////////////////////////////////////////////////////////////////////

  // Saturates at the last byte, oversize packets overwrite it
  assign offset_inc = put_q && !nak_q && !(&offset_q);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (state_i == ST_RCVD_OUT) begin
      offset_q <= '0;
    end else if ((state_i == ST_RCVD_DATA_START) && offset_inc) begin
      offset_q <= offset_q + 1'b1;
    end
  end

  assign ep_put_o.put    = put_q;
  assign ep_put_o.offset = offset_q;
  assign ep_put_o.data   = data_q;
  assign nak_o           = nak_q;

  // Offset holds at MAX_PKT_BYTES-1 rather than rolling over
  offset_no_wrap_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    ((state_i == ST_RCVD_DATA_START) && (&offset_q)) |=> (offset_q != '0));

endmodule

`default_nettype wire

// ==== hdl/usb_out_toggle_regs.sv ====
`default_nettype none

module usb_out_toggle_regs import usb_out_pkg::*; (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  rx_event_s              rx_event_i,
  input  logic [OUT_EP_W-1:0]    ep_idx_d_i,
  input  logic [OUT_EP_W-1:0]    ep_idx_q_i,
  input  logic                   new_pkt_end_i,
  input  logic                   datatog_we_i,
  input  logic [NUM_OUT_EPS-1:0] datatog_status_i,
  input  logic [NUM_OUT_EPS-1:0] datatog_mask_i,
  output logic [NUM_OUT_EPS-1:0] data_toggle_o,
  output logic [NUM_OUT_EPS-1:0] ep_setup_o
);

  logic [NUM_OUT_EPS-1:0] toggle_q;
  logic [NUM_OUT_EPS-1:0] toggle_d;

  //////////////////////////////////////////////////////////////////////
  // Data toggles
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    toggle_d = toggle_q;
    // SETUP restarts the sequence at DATA0
    if (rx_event_i.setup_clr) begin
      toggle_d[ep_idx_d_i] = 1'b0;
    end else if (new_pkt_end_i) begin
      toggle_d[ep_idx_q_i] = ~toggle_q[ep_idx_q_i];
    end
    // Software write wins over the hardware update
    if (datatog_we_i) begin
      toggle_d = (toggle_d & ~datatog_mask_i) | (datatog_status_i & datatog_mask_i);
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;
    end else begin
      toggle_q <= toggle_d;
    end
  end

  assign data_toggle_o = toggle_q;

  //////////////////////////////////////////////////////////////////////
  // SETUP flags
  //////////////////////////////////////////////////////////////////////

  // Set by SETUP, cleared by the next OUT on the same endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ep_setup_o <= '0;
    end else if (rx_event_i.setup_clr) begin
      ep_setup_o[ep_idx_d_i] <= 1'b1;
    end else if (rx_event_i.out_tok) begin
      ep_setup_o[ep_idx_d_i] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/usb_out_pe.sv ====
`default_nettype none

module usb_out_pe import usb_out_pkg::*; (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  logic [6:0]             dev_addr_i,
  // Receive side
  input  rx_pkt_s                rx_pkt_i,
  input  logic                   rx_data_put_i,
  input  logic [7:0]             rx_data_i,
  // Transmit side
  output logic                   tx_pkt_start_o,
  output usb_pid_e               tx_pid_o,
  // Software toggle access
  input  logic                   datatog_we_i,
  input  logic [NUM_OUT_EPS-1:0] datatog_status_i,
  input  logic [NUM_OUT_EPS-1:0] datatog_mask_i,
  output logic [NUM_OUT_EPS-1:0] data_toggle_o,
  // Endpoint side
  input  ep_cfg_s                ep_cfg_i,
  output ep_put_s                ep_put_o,
  output logic [OUT_EP_W-1:0]    ep_current_o,
  output logic                   ep_newpkt_o,
  output logic                   ep_acked_o,
  output logic                   ep_rollback_o,
  output logic [NUM_OUT_EPS-1:0] ep_setup_o
);

  rx_event_s           rx_event;
  logic [OUT_EP_W-1:0] ep_idx_d;
  out_state_e          state;
  logic                new_pkt_end;
  logic                nak_q;
  logic                ep_full;

  // Full bit of the endpoint in the running transaction
  assign ep_full = ep_cfg_i.full[ep_current_o];

  usb_out_token_decode u_token_decode (
    .rx_pkt_i      (rx_pkt_i),
    .dev_addr_i    (dev_addr_i),
    .ep_cfg_i      (ep_cfg_i),
    .data_toggle_i (data_toggle_o),
    .rx_event_o    (rx_event),
    .ep_idx_o      (ep_idx_d)
  );

  usb_out_xact_fsm u_xact_fsm (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .link_reset_i   (link_reset_i),
    .rx_pkt_start_i (rx_pkt_i.pkt_start),
    .rx_event_i     (rx_event),
    .ep_idx_i       (ep_idx_d),
    .ep_cfg_i       (ep_cfg_i),
    .nak_i          (nak_q),
    .state_o        (state),
    .xact_start_o   (),
    .new_pkt_end_o  (new_pkt_end),
    .ep_current_o   (ep_current_o),
    .ep_newpkt_o    (ep_newpkt_o),
    .ep_acked_o     (ep_acked_o),
    .ep_rollback_o  (ep_rollback_o),
    .tx_pkt_start_o (tx_pkt_start_o),
    .tx_pid_o       (tx_pid_o)
  );

  usb_out_data_path u_data_path (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .state_i       (state),
    .rx_data_put_i (rx_data_put_i),
    .rx_data_i     (rx_data_i),
    .ep_full_i     (ep_full),
    .ep_put_o      (ep_put_o),
    .nak_o         (nak_q)
  );

  usb_out_toggle_regs u_toggle_regs (
    .clk_48mhz_i      (clk_48mhz_i),
    .rst_ni           (rst_ni),
    .link_reset_i     (link_reset_i),
    .rx_event_i       (rx_event),
    .ep_idx_d_i       (ep_idx_d),
    .ep_idx_q_i       (ep_current_o),
    .new_pkt_end_i    (new_pkt_end),
    .datatog_we_i     (datatog_we_i),
    .datatog_status_i (datatog_status_i),
    .datatog_mask_i   (datatog_mask_i),
    .data_toggle_o    (data_toggle_o),
    .ep_setup_o       (ep_setup_o)
  );

endmodule

`default_nettype wire

// ==== testbench/usb_out_model.svh ====
`ifndef USB_OUT_MODEL_SVH
`define USB_OUT_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference state
//////////////////////////////////////////////////////////////////////

// One bit per implemented endpoint
logic [NUM_OUT_EPS-1:0] mdl_toggle;
logic [NUM_OUT_EPS-1:0] mdl_setup;

// Expected handshake of the running transaction
logic     exp_tx;
usb_pid_e exp_pid;
logic     exp_acked;
logic     exp_rollback;
// Response comes in the end strobe cycle itself
logic     exp_early;

// Token for this device on an implemented, enabled endpoint
function automatic logic ep_reachable(input logic match, input logic [3:0] ep,
                                      input ep_cfg_s cfg);
  if (!match || (ep >= 4'(NUM_OUT_EPS))) begin
    return 1'b0;
  end
  return cfg.enabled[ep[OUT_EP_W-1:0]];
endfunction

// SETUP additionally needs a control endpoint
function automatic logic token_starts(input logic is_setup, input logic match,
                                      input logic [3:0] ep, input ep_cfg_s cfg);
  if (!ep_reachable(match, ep, cfg)) begin
    return 1'b0;
  end
  return !is_setup || cfg.control[ep[OUT_EP_W-1:0]];
endfunction

// SETUP restarts at DATA0 and raises the flag, OUT drops the flag
task automatic model_token(input logic is_setup, input logic match,
                           input logic [3:0] ep, input ep_cfg_s cfg);
  logic [OUT_EP_W-1:0] idx;
  idx = ep[OUT_EP_W-1:0];
  if (ep_reachable(match, ep, cfg)) begin
    if (is_setup) begin
      mdl_toggle[idx] = 1'b0;
      mdl_setup[idx]  = 1'b1;
    end else begin
      mdl_setup[idx] = 1'b0;
    end
  end
endtask

// Handshake choice at the end of the data packet
task automatic model_data_end(input logic started, input logic is_setup,
                              input logic [OUT_EP_W-1:0] idx, input logic data_tog,
                              input logic crc_ok, input ep_cfg_s cfg);
  exp_tx       = 1'b0;
  exp_pid      = PID_ACK;
  exp_acked    = 1'b0;
  exp_rollback = 1'b0;
  exp_early    = 1'b0;
  if (!started) begin
    return;
  end
  if (!crc_ok) begin
    exp_early    = 1'b1;
    exp_rollback = 1'b1;
  end else if ((data_tog != mdl_toggle[idx]) && !cfg.stall[idx]) begin
    // Retransmission, host missed the last ACK
    exp_early    = 1'b1;
    exp_tx       = 1'b1;
    exp_rollback = 1'b1;
  end else if (is_setup) begin
    if (cfg.full[idx]) begin
      exp_rollback = 1'b1;
    end else begin
      exp_tx    = 1'b1;
      exp_acked = 1'b1;
    end
  end else if (cfg.stall[idx]) begin
    exp_tx  = 1'b1;
    exp_pid = PID_STALL;
  end else if (cfg.full[idx]) begin
    exp_tx       = 1'b1;
    exp_pid      = PID_NAK;
    exp_rollback = 1'b1;
  end else begin
    exp_tx    = 1'b1;
    exp_acked = 1'b1;
  end
  if (exp_acked) begin
    mdl_toggle[idx] = ~mdl_toggle[idx];
  end
endtask

// Software write touches only the masked toggles
task automatic model_sw_write(input logic [NUM_OUT_EPS-1:0] status,
                              input logic [NUM_OUT_EPS-1:0] mask);
  for (int i = 0; i < NUM_OUT_EPS; i++) begin
    if (mask[i]) begin
      mdl_toggle[i] = status[i];
    end
  end
endtask

`endif

// ==== testbench/tb_usb_out_pe.sv ====
`default_nettype none

module tb_usb_out_pe import usb_out_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_XACTS  = 300;

  logic                   clk_48mhz;
  logic                   rst_n;
  logic                   link_reset;
  logic [6:0]             dev_addr;
  rx_pkt_s                rx_pkt;
  logic                   rx_data_put;
  logic [7:0]             rx_data;
  logic                   tx_pkt_start;
  usb_pid_e               tx_pid;
  logic                   datatog_we;
  logic [NUM_OUT_EPS-1:0] datatog_status;
  logic [NUM_OUT_EPS-1:0] datatog_mask;
  logic [NUM_OUT_EPS-1:0] data_toggle;
  ep_cfg_s                ep_cfg;
  ep_put_s                ep_put;
  logic [OUT_EP_W-1:0]    ep_current;
  logic                   ep_newpkt;
  logic                   ep_acked;
  logic                   ep_rollback;
  logic [NUM_OUT_EPS-1:0] ep_setup;
  integer                 seed;

  `include "usb_out_model.svh"

  usb_out_pe dut_i (
    .clk_48mhz_i      (clk_48mhz),
    .rst_ni           (rst_n),
    .link_reset_i     (link_reset),
    .dev_addr_i       (dev_addr),
    .rx_pkt_i         (rx_pkt),
    .rx_data_put_i    (rx_data_put),
    .rx_data_i        (rx_data),
    .tx_pkt_start_o   (tx_pkt_start),
    .tx_pid_o         (tx_pid),
    .datatog_we_i     (datatog_we),
    .datatog_status_i (datatog_status),
    .datatog_mask_i   (datatog_mask),
    .data_toggle_o    (data_toggle),
    .ep_cfg_i         (ep_cfg),
    .ep_put_o         (ep_put),
    .ep_current_o     (ep_current),
    .ep_newpkt_o      (ep_newpkt),
    .ep_acked_o       (ep_acked),
    .ep_rollback_o    (ep_rollback),
    .ep_setup_o       (ep_setup)
  );

  initial begin
    clk_48mhz = 1'b0;
    forever #(CLK_PERIOD / 2) clk_48mhz = ~clk_48mhz;
  end

  // Generous bound, the longest transaction is the ACK timeout
  initial begin
    #(CLK_PERIOD * 200 * NUM_XACTS);
    $display("Watchdog expired before all transactions completed");
    $display("Result: FAILED");
    $fatal(1, "watchdog timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "check on %s", name);
    end
  endtask

  task automatic check_put(input logic started, input int k, input logic [7:0] data,
                           input logic full);
    check_value("ep_put_o.put", ep_put.put, started);
    if (started) begin
      check_value("ep_put_o.data", ep_put.data, data);
      // Full endpoint stops the offset once the NAK flag lands after the first put
      if (full) begin
        check_value("ep_put_o.offset", ep_put.offset, (k == 0) ? 0 : 1);
      end else begin
        check_value("ep_put_o.offset", ep_put.offset, k);
      end
    end
  endtask

  // Handshake strobes, all low unless this is the response cycle
  task automatic check_response(input logic active);
    check_value("tx_pkt_start_o", tx_pkt_start, active && exp_tx);
    check_value("ep_acked_o", ep_acked, active && exp_acked);
    check_value("ep_rollback_o", ep_rollback, active && exp_rollback);
    if (active && exp_tx) begin
      check_value("tx_pid_o", tx_pid, exp_pid);
    end
  endtask

  task automatic check_regs();
    check_value("data_toggle_o", data_toggle, mdl_toggle);
    check_value("ep_setup_o", ep_setup, mdl_setup);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic write_toggles();
    logic [31:0] r;
    r = $random(seed);
    @(negedge clk_48mhz);
    datatog_we     = 1'b1;
    datatog_status = r[NUM_OUT_EPS-1:0];
    datatog_mask   = r[NUM_OUT_EPS+7:8];
    model_sw_write(datatog_status, datatog_mask);
    @(negedge clk_48mhz);
    datatog_we = 1'b0;
    check_regs();
  endtask

  // Link reset clears the toggles but keeps the SETUP flags
  task automatic pulse_link_reset();
    @(negedge clk_48mhz);
    link_reset = 1'b1;
    mdl_toggle = '0;
    @(negedge clk_48mhz);
    link_reset = 1'b0;
    check_response(1'b0);
    check_value("ep_newpkt_o", ep_newpkt, 1'b0);
    check_value("ep_put_o.put", ep_put.put, 1'b0);
    check_regs();
  endtask

  task automatic run_xact();
    logic [31:0]         r;
    logic [31:0]         c;
    logic                is_setup;
    logic                match;
    logic [3:0]          ep;
    logic [OUT_EP_W-1:0] idx;
    logic                started;
    logic                data_tog;
    logic                crc_ok;
    int                  n_bytes;
    logic [7:0]          cur_byte;

    r        = $random(seed);
    c        = $random(seed);
    is_setup = r[0];
    ep       = {2'b00, r[2:1]};
    idx      = ep[OUT_EP_W-1:0];
    match    = (r[5:3] != 3'd0);
    n_bytes  = 1 + int'(r[8:6]);
    crc_ok   = (r[11:9] != 3'd0);

    // Token, with a configuration that holds for the whole transaction
    @(negedge clk_48mhz);
    ep_cfg.enabled    = c[1:0] | c[3:2];
    ep_cfg.control    = c[5:4];
    ep_cfg.full       = c[7:6] & c[9:8];
    ep_cfg.stall      = c[11:10] & c[13:12] & c[15:14];
    started           = token_starts(is_setup, match, ep, ep_cfg);
    rx_pkt.pkt_end    = 1'b1;
    rx_pkt.pkt_valid  = 1'b1;
    rx_pkt.pid        = is_setup ? PID_SETUP : PID_OUT;
    rx_pkt.addr       = match ? dev_addr : (dev_addr ^ (7'd1 + 7'(r[24:19])));
    rx_pkt.endp       = ep;
    @(negedge clk_48mhz);
    rx_pkt.pkt_end = 1'b0;
    model_token(is_setup, match, ep, ep_cfg);
    check_value("ep_newpkt_o", ep_newpkt, started);
    if (started) begin
      check_value("ep_current_o", ep_current, idx);
    end
    check_regs();

    // Host never sends data, FSM must give up quietly
    if (started && (r[18:15] == 4'd0)) begin
      // Sometimes a link reset cuts the wait short
      if (r[25]) begin
        pulse_link_reset();
        return;
      end
      repeat (ACK_TIMEOUT_CNT) begin
        @(negedge clk_48mhz);
        check_response(1'b0);
      end
      return;
    end

    // Mostly the expected toggle, sometimes a retransmission
    data_tog = (r[14:12] != 3'd0) ? mdl_toggle[idx] : ~mdl_toggle[idx];
    @(negedge clk_48mhz);
    rx_pkt.pkt_start = 1'b1;
    rx_pkt.pid       = data_tog ? PID_DATA1 : PID_DATA0;
    @(negedge clk_48mhz);
    rx_pkt.pkt_start = 1'b0;
    for (int k = 0; k < n_bytes; k++) begin
      cur_byte    = 8'($random(seed));
      rx_data_put = 1'b1;
      rx_data     = cur_byte;
      @(negedge clk_48mhz);
      check_put(started, k, cur_byte, ep_cfg.full[idx]);
    end
    rx_data_put = 1'b0;

    // End of data packet
    rx_pkt.pkt_end   = 1'b1;
    rx_pkt.pkt_valid = crc_ok;
    model_data_end(started, is_setup, idx, data_tog, crc_ok, ep_cfg);
    #1;
    check_response(exp_early);
    @(negedge clk_48mhz);
    rx_pkt.pkt_end   = 1'b0;
    rx_pkt.pkt_valid = 1'b1;
    check_response(!exp_early);
    check_value("ep_put_o.put", ep_put.put, 1'b0);
    @(negedge clk_48mhz);
    check_response(1'b0);
    check_regs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    seed           = 32'h26bb;
    rst_n          = 1'b0;
    link_reset     = 1'b0;
    dev_addr       = 7'($random(seed)) | 7'h01;
    rx_pkt         = '0;
    rx_data_put    = 1'b0;
    rx_data        = 8'h00;
    datatog_we     = 1'b0;
    datatog_status = '0;
    datatog_mask   = '0;
    ep_cfg         = '0;
    mdl_toggle     = '0;
    mdl_setup      = '0;
    exp_tx         = 1'b0;
    exp_pid        = PID_ACK;
    exp_acked      = 1'b0;
    exp_rollback   = 1'b0;
    exp_early      = 1'b0;

    repeat (4) @(negedge clk_48mhz);
    rst_n = 1'b1;
    @(negedge clk_48mhz);
    check_response(1'b0);
    check_value("ep_newpkt_o", ep_newpkt, 1'b0);
    check_regs();

    for (int i = 0; i < NUM_XACTS; i++) begin
      r = $random(seed);
      if (r[3:0] == 4'd0) begin
        write_toggles();
      end
      if (r[7:4] == 4'd0) begin
        pulse_link_reset();
      end
      run_xact();
    end

    repeat (2) @(negedge clk_48mhz);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== usb_out_pe.f ====
+incdir+testbench
hdl/usb_out_pkg.sv
hdl/usb_out_token_decode.sv
hdl/usb_out_xact_fsm.sv
hdl/usb_out_data_path.sv
hdl/usb_out_toggle_regs.sv
hdl/usb_out_pe.sv
testbench/tb_usb_out_pe.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_usb_out_pe
FILELIST  = usb_out_pe.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
